// File: logic/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

	localparam int NUM_STAGES = 4;
	localparam logic [31:0] EBASE_RESET = 32'hBFC00380;
	localparam int STATUS_IE_BIT = 0;
	localparam int STATUS_EXL_BIT = 1;

	typedef logic [31:0] addr_t;

	// Exception code carried by an instruction or assigned at MEM.
	typedef enum logic [4:0] {
		NONE = 5'h00,
		INT  = 5'h01,
		ADEL = 5'h02,
		ADES = 5'h03,
		SYS  = 5'h04,
		BP   = 5'h05,
		RI   = 5'h06,
		OV   = 5'h07,
		TR   = 5'h08,
		ERET = 5'h09
	} exc_code_e;

	typedef enum logic {
		EXCEPTION   = 1'b0,
		BRANCH_MISS = 1'b1
	} flush_cause_e;

	// Bit 0 blocks fetch intake, bits 1 to 3 hold ID, EX and MEM.
	typedef logic [3:0] stall_vec_t;

	localparam stall_vec_t STALL_NONE   = 4'b0000;
	localparam stall_vec_t STALL_ID     = 4'b0001;
	localparam stall_vec_t STALL_EX     = 4'b0011;
	localparam stall_vec_t STALL_DCACHE = 4'b0111;

	typedef enum logic [1:0] {
		EPC    = 2'd0,
		EBASE  = 2'd1,
		STATUS = 2'd2,
		CAUSE  = 2'd3
	} cp0_sel_e;

	typedef struct packed {
		logic      valid;
		addr_t     pc;
		exc_code_e exc;
	} slot_t;

	typedef struct packed {
		logic      taken;
		exc_code_e code;
		addr_t     pc;
	} exc_event_t;

	typedef struct packed {
		logic         valid;
		flush_cause_e cause;
		addr_t        pc;
	} redirect_t;

endpackage

`default_nettype wire

// File: logic/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
	input  logic                      arst_n_i,
	input  pipe_ctrl_pkg::exc_event_t exc_i,
	input  logic                      stall_id_i,
	input  logic                      stall_ex_i,
	input  logic                      stall_dcache_i,
	input  logic                      mispredict_i,
	input  pipe_ctrl_pkg::addr_t      epc_i,
	input  pipe_ctrl_pkg::addr_t      ebase_i,
	output pipe_ctrl_pkg::stall_vec_t stall_o,
	output logic                      flush_o,
	output pipe_ctrl_pkg::flush_cause_e cause_o,
	output pipe_ctrl_pkg::redirect_t  redirect_o
);

	pipe_ctrl_pkg::addr_t target;

	always_comb begin
		if (!arst_n_i) begin
			stall_o = pipe_ctrl_pkg::STALL_NONE; // Nothing moves or flushes in reset.
			flush_o = 1'b0;
			cause_o = pipe_ctrl_pkg::EXCEPTION;
			target  = '0;
		end else if (exc_i.taken) begin
			stall_o = pipe_ctrl_pkg::STALL_NONE;
			flush_o = 1'b1;
			cause_o = pipe_ctrl_pkg::EXCEPTION;
			case (exc_i.code)
				pipe_ctrl_pkg::INT, pipe_ctrl_pkg::ADEL, pipe_ctrl_pkg::ADES,
				pipe_ctrl_pkg::SYS, pipe_ctrl_pkg::BP, pipe_ctrl_pkg::RI,
				pipe_ctrl_pkg::OV, pipe_ctrl_pkg::TR: begin
					target = ebase_i;
				end
				pipe_ctrl_pkg::ERET: begin
					target = epc_i; // Return to the interrupted instruction.
				end
				default: begin
					target = '0;
				end
			endcase
		end else if (stall_dcache_i) begin
			stall_o = pipe_ctrl_pkg::STALL_DCACHE; // MEM still drains.
			flush_o = 1'b0;
			cause_o = pipe_ctrl_pkg::EXCEPTION;
			target  = '0;
		end else if (mispredict_i) begin
			stall_o = pipe_ctrl_pkg::STALL_NONE;
			flush_o = 1'b1;
			cause_o = pipe_ctrl_pkg::BRANCH_MISS;
			target  = '0; // Fetch already knows the branch target.
		end else if (stall_ex_i) begin
			stall_o = pipe_ctrl_pkg::STALL_EX;
			flush_o = 1'b0;
			cause_o = pipe_ctrl_pkg::EXCEPTION;
			target  = '0;
		end else if (stall_id_i) begin
			stall_o = pipe_ctrl_pkg::STALL_ID;
			flush_o = 1'b0;
			cause_o = pipe_ctrl_pkg::EXCEPTION;
			target  = '0;
		end else begin
			stall_o = pipe_ctrl_pkg::STALL_NONE;
			flush_o = 1'b0;
			cause_o = pipe_ctrl_pkg::EXCEPTION;
			target  = '0;
		end
	end

	assign redirect_o = '{valid: flush_o, cause: cause_o, pc: target};

endmodule

`default_nettype wire

// File: logic/exc_detect.sv
`timescale 1ns/1ps
`default_nettype none

module exc_detect (
	input  pipe_ctrl_pkg::slot_t      mem_i,
	input  logic                      irq_i,
	input  logic                      int_enable_i,
	output pipe_ctrl_pkg::exc_event_t exc_o
);

	logic irq_pending;

	assign irq_pending = irq_i && int_enable_i;

	// An interrupt is charged to whichever instruction sits in MEM.
	always_comb begin
		exc_o.pc = mem_i.pc;
		if (!mem_i.valid) begin
			exc_o.taken = 1'b0; // A bubble never raises anything.
			exc_o.code  = pipe_ctrl_pkg::NONE;
		end else if (irq_pending) begin
			exc_o.taken = 1'b1;
			exc_o.code  = pipe_ctrl_pkg::INT;
		end else begin
			exc_o.taken = (mem_i.exc != pipe_ctrl_pkg::NONE);
			exc_o.code  = mem_i.exc;
		end
	end

endmodule

`default_nettype wire

// File: logic/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  pipe_ctrl_pkg::exc_event_t exc_i,
	input  logic                      we_i,
	input  pipe_ctrl_pkg::cp0_sel_e   sel_i,
	input  logic [31:0]               wdata_i,
	output logic [31:0]               rdata_o,
	output pipe_ctrl_pkg::addr_t      epc_o,
	output pipe_ctrl_pkg::addr_t      ebase_o,
	output logic                      int_enable_o
);

	pipe_ctrl_pkg::addr_t epc_q;
	pipe_ctrl_pkg::addr_t ebase_q;
	logic [31:0]          status_q;
	logic [31:0]          cause_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			epc_q    <= '0;
			ebase_q  <= pipe_ctrl_pkg::EBASE_RESET;
			status_q <= '0;
			cause_q  <= '0;
		end else if (exc_i.taken) begin
			if (exc_i.code == pipe_ctrl_pkg::ERET) begin
				status_q[pipe_ctrl_pkg::STATUS_EXL_BIT] <= 1'b0; // EPC stays as it was.
			end else begin
				epc_q <= exc_i.pc;
				status_q[pipe_ctrl_pkg::STATUS_EXL_BIT] <= 1'b1;
				cause_q[4:0] <= exc_i.code; // Code sits in the low five bits.
			end
		end else if (we_i) begin
			case (sel_i)
				pipe_ctrl_pkg::EPC:    epc_q    <= wdata_i;
				pipe_ctrl_pkg::EBASE:  ebase_q  <= wdata_i;
				pipe_ctrl_pkg::STATUS: status_q <= wdata_i;
				pipe_ctrl_pkg::CAUSE:  cause_q  <= wdata_i;
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		case (sel_i)
			pipe_ctrl_pkg::EPC:    rdata_o = epc_q;
			pipe_ctrl_pkg::EBASE:  rdata_o = ebase_q;
			pipe_ctrl_pkg::STATUS: rdata_o = status_q;
			pipe_ctrl_pkg::CAUSE:  rdata_o = cause_q;
			default:               rdata_o = '0;
		endcase
	end

	assign epc_o   = epc_q;
	assign ebase_o = ebase_q;

	// Interrupts are masked while an exception handler runs.
	assign int_enable_o = status_q[pipe_ctrl_pkg::STATUS_IE_BIT] &&
		!status_q[pipe_ctrl_pkg::STATUS_EXL_BIT];

endmodule

`default_nettype wire

// File: logic/stage_chain.sv
`timescale 1ns/1ps
`default_nettype none

module stage_chain (
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  pipe_ctrl_pkg::slot_t        fetch_i,
	input  pipe_ctrl_pkg::stall_vec_t   stall_i,
	input  logic                        flush_i,
	input  pipe_ctrl_pkg::flush_cause_e cause_i,
	output logic                        fetch_ready_o,
	output pipe_ctrl_pkg::slot_t        mem_o,
	output logic                        retire_o,
	output pipe_ctrl_pkg::addr_t        retire_pc_o
);

	// Index 0 is IF and the last index is MEM.
	pipe_ctrl_pkg::slot_t slot_q [pipe_ctrl_pkg::NUM_STAGES];
	pipe_ctrl_pkg::slot_t slot_d [pipe_ctrl_pkg::NUM_STAGES];

	logic run_q;
	logic accept;
	logic exc_flush;
	logic miss_flush;

	assign exc_flush  = flush_i && (cause_i == pipe_ctrl_pkg::EXCEPTION);
	assign miss_flush = flush_i && (cause_i == pipe_ctrl_pkg::BRANCH_MISS);

	assign fetch_ready_o = run_q && !stall_i[0] && !flush_i; // run_q stays low through reset.
	assign accept        = fetch_i.valid && fetch_ready_o;

	always_comb begin
		if (stall_i[0]) begin
			slot_d[0] = slot_q[0];
		end else if (accept) begin
			slot_d[0] = fetch_i;
		end else begin
			slot_d[0] = '0;
		end

		for (int k = 1; k < pipe_ctrl_pkg::NUM_STAGES; k++) begin
			if (stall_i[k]) begin
				slot_d[k] = slot_q[k];
			end else if (stall_i[k-1]) begin
				slot_d[k] = '0; // Held stage behind, so a bubble moves in.
			end else begin
				slot_d[k] = slot_q[k-1];
			end
		end

		if (exc_flush) begin
			for (int k = 0; k < pipe_ctrl_pkg::NUM_STAGES; k++) begin
				slot_d[k] = '0;
			end
		end else if (miss_flush) begin
			// The IF and ID instructions die here and EX still moves on to MEM.
			slot_d[0] = '0;
			slot_d[1] = '0;
			slot_d[2] = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			run_q <= 1'b0;
			for (int k = 0; k < pipe_ctrl_pkg::NUM_STAGES; k++) begin
				slot_q[k] <= '0;
			end
		end else begin
			run_q  <= 1'b1;
			slot_q <= slot_d;
		end
	end

	assign mem_o       = slot_q[pipe_ctrl_pkg::NUM_STAGES-1];
	assign retire_o    = mem_o.valid && !exc_flush; // An excepting instruction never retires.
	assign retire_pc_o = mem_o.pc;

endmodule

`default_nettype wire

// File: logic/pipe_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  pipe_ctrl_pkg::slot_t      fetch_i,
	input  logic                      stall_id_i,
	input  logic                      stall_ex_i,
	input  logic                      stall_dcache_i,
	input  logic                      mispredict_i,
	input  logic                      irq_i,
	input  logic                      cp0_we_i,
	input  pipe_ctrl_pkg::cp0_sel_e   cp0_sel_i,
	input  logic [31:0]               cp0_wdata_i,
	output logic                      fetch_ready_o,
	output logic                      retire_o,
	output pipe_ctrl_pkg::addr_t      retire_pc_o,
	output pipe_ctrl_pkg::redirect_t  redirect_o,
	output logic [31:0]               cp0_rdata_o,
	output pipe_ctrl_pkg::stall_vec_t stall_o
);

	pipe_ctrl_pkg::slot_t         mem_slot;
	pipe_ctrl_pkg::exc_event_t    exc_event;
	pipe_ctrl_pkg::addr_t         epc;
	pipe_ctrl_pkg::addr_t         ebase;
	logic                         int_enable;
	logic                         flush;
	pipe_ctrl_pkg::flush_cause_e  cause;

	hazard_ctrl u_hazard_ctrl (
		.arst_n_i       (arst_n_i),
		.exc_i          (exc_event),
		.stall_id_i     (stall_id_i),
		.stall_ex_i     (stall_ex_i),
		.stall_dcache_i (stall_dcache_i),
		.mispredict_i   (mispredict_i),
		.epc_i          (epc),
		.ebase_i        (ebase),
		.stall_o        (stall_o),
		.flush_o        (flush),
		.cause_o        (cause),
		.redirect_o     (redirect_o)
	);

	exc_detect u_exc_detect (
		.mem_i        (mem_slot),
		.irq_i        (irq_i),
		.int_enable_i (int_enable),
		.exc_o        (exc_event)
	);

	cp0_regs u_cp0_regs (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.exc_i        (exc_event),
		.we_i         (cp0_we_i),
		.sel_i        (cp0_sel_i),
		.wdata_i      (cp0_wdata_i),
		.rdata_o      (cp0_rdata_o),
		.epc_o        (epc),
		.ebase_o      (ebase),
		.int_enable_o (int_enable)
	);

	stage_chain u_stage_chain (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.fetch_i       (fetch_i),
		.stall_i       (stall_o),
		.flush_i       (flush),
		.cause_i       (cause),
		.fetch_ready_o (fetch_ready_o),
		.mem_o         (mem_slot),
		.retire_o      (retire_o),
		.retire_pc_o   (retire_pc_o)
	);

endmodule

`default_nettype wire

// File: bench/pipe_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_properties (
	input logic                      clk,
	input logic                      arst_n_i,
	input pipe_ctrl_pkg::stall_vec_t stall_i,
	input pipe_ctrl_pkg::redirect_t  redirect_i,
	input logic                      fetch_ready_i,
	input logic                      retire_i,
	input pipe_ctrl_pkg::slot_t      mem_slot_i
);

	// Only the four codes of the priority chain may appear.
	a_legal_stall: assert property (@(posedge clk)
		stall_i inside {4'b0000, 4'b0001, 4'b0011, 4'b0111})
		else $error("stall vector holds an illegal code");

	a_redirect_blocks_fetch: assert property (@(posedge clk)
		redirect_i.valid |-> !fetch_ready_i)
		else $error("fetch intake open during a redirect");

	a_no_retire_on_exception: assert property (@(posedge clk)
		!(retire_i && redirect_i.valid && redirect_i.cause == pipe_ctrl_pkg::EXCEPTION))
		else $error("instruction retired in an exception redirect cycle");

	a_idle_in_reset: assert property (@(posedge clk)
		!arst_n_i |-> !(fetch_ready_i || retire_i || redirect_i.valid || mem_slot_i.valid))
		else $error("activity seen while reset is asserted");

endmodule

bind pipe_ctrl_top pipe_ctrl_properties u_properties (
	.clk           (clk),
	.arst_n_i      (arst_n_i),
	.stall_i       (stall_o),
	.redirect_i    (redirect_o),
	.fetch_ready_i (fetch_ready_o),
	.retire_i      (retire_o),
	.mem_slot_i    (mem_slot)
);

`default_nettype wire

// File: bench/pipe_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb;

	localparam int CYCLE_LIMIT = 40 + 40 + 35 + 25 + 40 + 60 + 100; // Test budgets plus margin.

	logic                        clk;
	logic                        arst_n_i;
	pipe_ctrl_pkg::slot_t        fetch_i;
	logic                        stall_id_i;
	logic                        stall_ex_i;
	logic                        stall_dcache_i;
	logic                        mispredict_i;
	logic                        irq_i;
	logic                        cp0_we_i;
	pipe_ctrl_pkg::cp0_sel_e     cp0_sel_i;
	logic [31:0]                 cp0_wdata_i;
	logic                        fetch_ready_o;
	logic                        retire_o;
	pipe_ctrl_pkg::addr_t        retire_pc_o;
	pipe_ctrl_pkg::redirect_t    redirect_o;
	logic [31:0]                 cp0_rdata_o;
	pipe_ctrl_pkg::stall_vec_t   stall_o;

	logic [31:0] pc_q [$]; // Accepted PCs, oldest first.
	int          acc_q [$];
	int          cycle_cnt = 0;
	int          retired_cnt = 0;
	int          exc_redirect_cnt = 0;
	int          fail_count = 0;
	logic        check_latency = 1'b0;
	logic [31:0] rng_state = 32'd27;
	logic [31:0] exp_epc;
	logic [31:0] cur_ebase;

	pipe_ctrl_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string line);
		fail_count++;
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	function logic [31:0] next_pc();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return {x[31:2], 2'b00}; // Word aligned.
	endfunction

	// Scoreboard. Retires pop the head, flushes drop the entries they kill.
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			fail_run("The run went past its cycle limit without finishing.");
		end else if (arst_n_i) begin
			if (retire_o) begin
				if (pc_q.size() == 0) begin
					fail_run("An instruction retired although none was expected.");
				end else begin
					check_val("retire_pc_o", retire_pc_o, pc_q[0]);
					if (check_latency) begin
						check_val("retire latency", cycle_cnt - acc_q[0], 4);
					end
					void'(pc_q.pop_front());
					void'(acc_q.pop_front());
					retired_cnt++;
				end
			end
			if (redirect_o.valid && redirect_o.cause == pipe_ctrl_pkg::EXCEPTION) begin
				pc_q.delete();
				acc_q.delete();
				exc_redirect_cnt++;
			end else if (redirect_o.valid) begin
				for (int k = 0; k < 2; k++) begin
					if (pc_q.size() > 0) begin
						void'(pc_q.pop_back()); // IF and ID hold the youngest two.
						void'(acc_q.pop_back());
					end
				end
			end
			if (fetch_i.valid && fetch_ready_o) begin
				pc_q.push_back(fetch_i.pc);
				acc_q.push_back(cycle_cnt);
			end
		end
	end

	task automatic feed(input logic [31:0] pc, input pipe_ctrl_pkg::exc_code_e code);
		fetch_i = '{valid: 1'b1, pc: pc, exc: code};
		#1;
		while (!fetch_ready_o) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
	endtask

	task automatic fetch_off();
		fetch_i = '0;
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (pc_q.size() != 0) begin
			if (n == max_cycles) begin
				fail_run("An accepted instruction did not retire before the cycle limit.");
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_redirect(input int max_cycles);
		int n;
		n = 0;
		#1;
		while (!redirect_o.valid) begin
			if (n == max_cycles) begin
				fail_run("No redirect appeared within the expected cycles.");
			end
			@(negedge clk);
			#1;
			n++;
		end
	endtask

	task automatic cp0_write(input pipe_ctrl_pkg::cp0_sel_e sel, input logic [31:0] data);
		cp0_we_i = 1'b1;
		cp0_sel_i = sel;
		cp0_wdata_i = data;
		@(negedge clk);
		cp0_we_i = 1'b0;
	endtask

	task automatic cp0_expect(input pipe_ctrl_pkg::cp0_sel_e sel, input logic [31:0] exp,
		input string name);
		cp0_sel_i = sel;
		#1;
		check_val(name, cp0_rdata_o, exp);
		@(negedge clk);
	endtask

	task automatic apply_stall(input logic id, input logic ex, input logic dc,
		input logic [3:0] exp_vec, input int n);
		repeat (n) begin
			stall_id_i = id;
			stall_ex_i = ex;
			stall_dcache_i = dc;
			#1;
			check_val("stall_o", stall_o, exp_vec);
			check_val("fetch_ready_o", fetch_ready_o, 1'b0);
			@(negedge clk);
		end
		stall_id_i = 1'b0;
		stall_ex_i = 1'b0;
		stall_dcache_i = 1'b0;
	endtask

	task automatic test_reset_flow();
		int base;
		repeat (15) @(negedge clk);
		#1;
		check_val("fetch_ready_o", fetch_ready_o, 1'b0);
		check_val("retire_o", retire_o, 1'b0);
		check_val("redirect_o.valid", redirect_o.valid, 1'b0);
		check_val("stall_o", stall_o, 4'b0000);
		@(negedge clk);
		arst_n_i = 1'b1;
		cp0_expect(pipe_ctrl_pkg::CAUSE, 32'h0, "Cause");
		cp0_expect(pipe_ctrl_pkg::STATUS, 32'h0, "Status");
		cp0_expect(pipe_ctrl_pkg::EBASE, 32'hBFC00380, "EBase");
		base = retired_cnt;
		check_latency = 1'b1;
		repeat (6) feed(next_pc(), pipe_ctrl_pkg::NONE);
		fetch_off();
		wait_drain(12);
		check_latency = 1'b0;
		check_val("retired count", retired_cnt - base, 6);
	endtask

	task automatic test_stalls();
		int base;
		logic [31:0] held;
		base = retired_cnt;
		repeat (4) feed(next_pc(), pipe_ctrl_pkg::NONE);
		for (int s = 0; s < 4; s++) begin
			held = next_pc();
			fetch_i = '{valid: 1'b1, pc: held, exc: pipe_ctrl_pkg::NONE}; // Waits behind the stall.
			case (s)
				0: apply_stall(1'b1, 1'b0, 1'b0, 4'b0001, 2);
				1: apply_stall(1'b0, 1'b1, 1'b0, 4'b0011, 2);
				2: apply_stall(1'b0, 1'b0, 1'b1, 4'b0111, 2);
				default: apply_stall(1'b1, 1'b1, 1'b1, 4'b0111, 2);
			endcase
			feed(held, pipe_ctrl_pkg::NONE);
			repeat (2) feed(next_pc(), pipe_ctrl_pkg::NONE); // Refill so every stage is busy.
		end
		fetch_off();
		wait_drain(12);
		check_val("retired count", retired_cnt - base, 16);
	endtask

	task automatic test_mispredict();
		int base;
		base = retired_cnt;
		repeat (4) feed(next_pc(), pipe_ctrl_pkg::NONE);
		fetch_off();
		mispredict_i = 1'b1;
		#1;
		check_val("redirect_o.valid", redirect_o.valid, 1'b1);
		check_val("redirect_o.cause", redirect_o.cause, pipe_ctrl_pkg::BRANCH_MISS);
		check_val("redirect_o.pc", redirect_o.pc, 32'h0);
		check_val("retire_o", retire_o, 1'b1); // MEM still retires under a branch flush.
		@(negedge clk);
		mispredict_i = 1'b0;
		wait_drain(8);
		repeat (4) @(negedge clk);
		check_val("retired count", retired_cnt - base, 2);
		base = retired_cnt;
		repeat (4) feed(next_pc(), pipe_ctrl_pkg::NONE);
		fetch_off();
		stall_dcache_i = 1'b1;
		mispredict_i = 1'b1;
		#1;
		check_val("stall_o", stall_o, 4'b0111); // The dcache stall outranks the miss.
		check_val("redirect_o.valid", redirect_o.valid, 1'b0);
		@(negedge clk);
		stall_dcache_i = 1'b0;
		#1;
		check_val("redirect_o.valid", redirect_o.valid, 1'b1);
		check_val("redirect_o.cause", redirect_o.cause, pipe_ctrl_pkg::BRANCH_MISS);
		@(negedge clk);
		mispredict_i = 1'b0;
		wait_drain(8);
		repeat (6) @(negedge clk);
		check_val("retired count", retired_cnt - base, 2);
	endtask

	task automatic test_sync_exception();
		int base;
		logic [31:0] p_sys;
		base = retired_cnt;
		feed(next_pc(), pipe_ctrl_pkg::NONE);
		p_sys = next_pc();
		feed(p_sys, pipe_ctrl_pkg::SYS);
		repeat (2) feed(next_pc(), pipe_ctrl_pkg::NONE);
		fetch_off();
		wait_redirect(6);
		check_val("redirect_o.cause", redirect_o.cause, pipe_ctrl_pkg::EXCEPTION);
		check_val("redirect_o.pc", redirect_o.pc, 32'hBFC00380);
		check_val("retire_o", retire_o, 1'b0);
		@(negedge clk);
		exp_epc = p_sys;
		cp0_expect(pipe_ctrl_pkg::EPC, exp_epc, "EPC");
		cp0_expect(pipe_ctrl_pkg::CAUSE, 32'(pipe_ctrl_pkg::SYS), "Cause");
		cp0_expect(pipe_ctrl_pkg::STATUS, 32'h2, "Status");
		repeat (6) @(negedge clk);
		check_val("retired count", retired_cnt - base, 1);
	endtask

	task automatic test_eret_ebase();
		logic [31:0] p_bp;
		cur_ebase = 32'h8000_0200;
		cp0_write(pipe_ctrl_pkg::EBASE, cur_ebase);
		feed(next_pc(), pipe_ctrl_pkg::ERET);
		fetch_off();
		wait_redirect(6);
		check_val("redirect_o.pc", redirect_o.pc, exp_epc);
		check_val("redirect_o.cause", redirect_o.cause, pipe_ctrl_pkg::EXCEPTION);
		@(negedge clk);
		cp0_expect(pipe_ctrl_pkg::STATUS, 32'h0, "Status");
		cp0_expect(pipe_ctrl_pkg::EPC, exp_epc, "EPC");
		p_bp = next_pc();
		feed(p_bp, pipe_ctrl_pkg::BP);
		fetch_off();
		wait_redirect(6);
		check_val("redirect_o.pc", redirect_o.pc, cur_ebase);
		@(negedge clk);
		exp_epc = p_bp;
		cp0_expect(pipe_ctrl_pkg::EPC, exp_epc, "EPC");
		cp0_expect(pipe_ctrl_pkg::CAUSE, 32'(pipe_ctrl_pkg::BP), "Cause");
		cp0_expect(pipe_ctrl_pkg::STATUS, 32'h2, "Status");
	endtask

	task automatic test_interrupt();
		int base;
		int exc_base;
		logic [31:0] p_int;
		cp0_write(pipe_ctrl_pkg::STATUS, 32'h1);
		base = retired_cnt;
		irq_i = 1'b1;
		p_int = next_pc();
		feed(p_int, pipe_ctrl_pkg::NONE);
		feed(next_pc(), pipe_ctrl_pkg::NONE);
		fetch_off();
		wait_redirect(6);
		check_val("redirect_o.pc", redirect_o.pc, cur_ebase);
		check_val("retire_o", retire_o, 1'b0);
		@(negedge clk);
		cp0_expect(pipe_ctrl_pkg::EPC, p_int, "EPC");
		cp0_expect(pipe_ctrl_pkg::CAUSE, 32'(pipe_ctrl_pkg::INT), "Cause");
		cp0_expect(pipe_ctrl_pkg::STATUS, 32'h3, "Status");
		check_val("retired count", retired_cnt - base, 0);
		exc_base = exc_redirect_cnt;
		feed(next_pc(), pipe_ctrl_pkg::NONE); // EXL still set, so irq_i is masked.
		fetch_off();
		wait_drain(8);
		cp0_write(pipe_ctrl_pkg::STATUS, 32'h0);
		feed(next_pc(), pipe_ctrl_pkg::NONE);
		fetch_off();
		wait_drain(8);
		irq_i = 1'b0;
		check_val("retired count", retired_cnt - base, 2);
		check_val("exception redirects", exc_redirect_cnt - exc_base, 0);
	endtask

	initial begin
		arst_n_i = 1'b0;
		fetch_i = '0;
		stall_id_i = 1'b0;
		stall_ex_i = 1'b0;
		stall_dcache_i = 1'b0;
		mispredict_i = 1'b0;
		irq_i = 1'b0;
		cp0_we_i = 1'b0;
		cp0_sel_i = pipe_ctrl_pkg::EPC;
		cp0_wdata_i = '0;
		test_reset_flow();
		test_stalls();
		test_mispredict();
		test_sync_exception();
		test_eret_ebase();
		test_interrupt();
		if (fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
logic/pipe_ctrl_pkg.sv
logic/hazard_ctrl.sv
logic/exc_detect.sv
logic/cp0_regs.sv
logic/stage_chain.sv
logic/pipe_ctrl_top.sv
bench/pipe_ctrl_properties.sv
bench/pipe_ctrl_tb.sv
